/* verilog.f */
+incdir+common
common/z80_isa_pkg.sv
common/z80_bus_pkg.sv
verilog/alu.sv
verilog/reg_file.sv
control/decode.sv
control/sequencer.sv
verilog/z80_top.sv
bench/z80_checker.sv
bench/tb_z80_top.sv

/* bench/tb_z80_top.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bench for the reduced Z80 core; random program,
// memory and I/O model with random wait states
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "z80_macros.svh"

module tb_z80_top;
timeunit 1ns;
timeprecision 100ps;

localparam int IMAGE_BYTES  = 512;
localparam int PROG_INSTRS  = 200;
localparam int QUIET_CYCLES = 12;
// Worst instruction is OUT with three 3-clock cycles all stretched to the limit
localparam int TIMEOUT_CYCLES = PROG_INSTRS * 9 * (1 + `Z80_MAX_WAIT) + 100;

logic                   clk;
logic                   rst_n;
logic [`Z80_DATA_W-1:0] din;
logic                   n_wait;
logic [`Z80_ADDR_W-1:0] addr;
logic [`Z80_DATA_W-1:0] dout;
logic                   dout_en;
logic                   n_m1;
logic                   n_mreq;
logic                   n_iorq;
logic                   n_rd;
logic                   n_wr;
logic                   n_halt;

logic [IMAGE_BYTES-1:0][7:0] mem;
logic        image_ready;
logic        run_done;
int unsigned lcg_state = 47;
int          wait_draw;
int          wait_left = 0;
int          cycle_count;
int          checker_errors;
int          timeout_errors = 0;

always #10 clk = ~clk;

// LCG step returning the better upper bits
function automatic int unsigned rand_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state >> 16;
endfunction

// Any register code except (HL)
function automatic logic [2:0] pick_reg();
    int unsigned r;
    r = rand_next() % 7;
    return (r == 6) ? 3'd7 : 3'(r);
endfunction

// Random program in the subset closed by HALT
task automatic build_program();
    int pc;
    int kind;
    for (int i = 0; i < IMAGE_BYTES; i++) mem[i] = 8'(i) ^ 8'(i >> 8) ^ 8'h5a;
    pc = `Z80_RESET_PC;
    for (int i = 0; i < PROG_INSTRS - 1; i++) begin
        kind = rand_next() % 10;
        case (kind)
            0:       mem[pc] = 8'h00;
            1, 2:    mem[pc] = {2'b00, pick_reg(), 3'b110};
            3, 4:    mem[pc] = {2'b01, pick_reg(), pick_reg()};
            5, 6, 7: mem[pc] = {2'b10, 3'(rand_next()), pick_reg()};
            default: mem[pc] = 8'hD3;
        endcase
        // Immediate byte of LD r,n and port byte of OUT
        if (kind inside {1, 2, 8, 9}) begin
            mem[pc + 1] = 8'(rand_next());
            pc += 2;
        end else begin
            pc += 1;
        end
    end
    mem[pc] = 8'h76;
endtask

task automatic finish_run();
    $display("errors: checker %0d, timeout %0d", checker_errors, timeout_errors);
    if (checker_errors + timeout_errors == 0) begin
        $display("*** TEST PASSED ***");
    end else begin
        $display("*** TEST FAILED ***");
    end
    $finish;
endtask

z80_top i_dut (
    .clk     (clk),
    .rst_n   (rst_n),
    .din     (din),
    .n_wait  (n_wait),
    .addr    (addr),
    .dout    (dout),
    .dout_en (dout_en),
    .n_m1    (n_m1),
    .n_mreq  (n_mreq),
    .n_iorq  (n_iorq),
    .n_rd    (n_rd),
    .n_wr    (n_wr),
    .n_halt  (n_halt)
);

z80_checker #(.IMAGE_BYTES(IMAGE_BYTES)) i_checker (
    .clk, .rst_n, .image_ready, .run_done, .image(mem), .addr, .dout, .dout_en,
    .n_m1, .n_mreq, .n_iorq, .n_rd, .n_wr, .n_halt, .error_count(checker_errors)
);

//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Memory and I/O model
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
always @(posedge clk) begin
    if (n_mreq && n_iorq) begin
        // Wait count for this cycle is drawn on the edge ending T1
        wait_draw = rand_next() % (`Z80_MAX_WAIT + 1);
        wait_left <= wait_draw;
        n_wait    <= (wait_draw == 0);
    end else if (wait_left > 0) begin
        wait_left <= wait_left - 1;
        n_wait    <= (wait_left == 1);
    end
    // Read data valid from the end of T2 through T3
    if (!n_rd) din <= mem[addr % IMAGE_BYTES];
end

initial begin
    clk = 1'b0;
    rst_n = 1'b0;
    din = '0;
    n_wait = 1'b1;
    image_ready = 1'b0;
    run_done = 1'b0;
    build_program();
    image_ready <= 1'b1;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    wait (n_halt === 1'b0);
    // Quiet window to catch strobes after HALT
    repeat (QUIET_CYCLES) @(posedge clk);
    run_done <= 1'b1;
    repeat (2) @(posedge clk);
    finish_run();
end

initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
        @(posedge clk);
        cycle_count++;
    end
    $display("timeout: no HALT within %0d cycles", TIMEOUT_CYCLES);
    timeout_errors = 1;
    finish_run();
end

endmodule

/* bench/z80_checker.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bus checker for the Z80 core bench; predicts the
// fetch and I/O write trace from the program image
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "z80_macros.svh"

module z80_checker #(
    parameter int IMAGE_BYTES = 512
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        image_ready,
    input  logic                        run_done,
    input  logic [IMAGE_BYTES-1:0][7:0] image,
    input  logic [`Z80_ADDR_W-1:0]      addr,
    input  logic [`Z80_DATA_W-1:0]      dout,
    input  logic                        dout_en,
    input  logic                        n_m1,
    input  logic                        n_mreq,
    input  logic                        n_iorq,
    input  logic                        n_rd,
    input  logic                        n_wr,
    input  logic                        n_halt,
    output int                          error_count
);
timeunit 1ns;
timeprecision 100ps;

// Expected trace consumed front to back
logic [`Z80_ADDR_W-1:0] exp_fetch [$];
logic [7:0]             exp_port [$];
logic [7:0]             exp_data [$];
logic [`Z80_ADDR_W-1:0] want_addr;
logic [7:0]             want_port;
logic [7:0]             want_data;
int                     io_expected;
int                     io_seen;
int                     fetch_seen;
logic                   last_n_wr;
logic                   final_done;

// Accumulator op on 9 bits with the new carry in bit 8 (borrow for subtracts)
function automatic logic [8:0] alu_ref(input logic [2:0] op, input logic [7:0] a,
                                       input logic [7:0] b, input logic c);
    logic [8:0] t;
    case (op)
        3'd0:    t = {1'b0, a} + {1'b0, b};
        3'd1:    t = {1'b0, a} + {1'b0, b} + {8'd0, c};
        3'd3:    t = {1'b0, a} - {1'b0, b} - {8'd0, c};
        3'd4:    t = {1'b0, a & b};
        3'd5:    t = {1'b0, a ^ b};
        3'd6:    t = {1'b0, a | b};
        default: t = {1'b0, a} - {1'b0, b};
    endcase
    // CP keeps A and only moves the carry
    if (op == 3'd7) t[7:0] = a;
    return t;
endfunction

// Steps the instruction-set model over the image up to HALT
function automatic void predict_bus_trace();
    logic [7:0]  regs [8];
    logic [15:0] pc;
    logic [7:0]  op;
    logic [8:0]  t;
    logic        carry;
    logic        halted;
    int          len;
    for (int r = 0; r < 8; r++) regs[r] = 8'h00;
    pc = `Z80_RESET_PC;
    carry = 1'b0;
    halted = 1'b0;
    io_expected = 0;
    for (int step = 0; step < 2 * IMAGE_BYTES && !halted; step++) begin
        exp_fetch.push_back(pc);
        op = image[pc % IMAGE_BYTES];
        len = 1;
        case (op[7:6])
            2'b00: begin
                // LD r,n; (HL) target and the rest act as NOP
                if (op[2:0] == 3'd6 && op[5:3] != 3'd6) begin
                    regs[op[5:3]] = image[(pc + 1) % IMAGE_BYTES];
                    len = 2;
                end
            end
            2'b01: begin
                if (op == 8'h76) begin
                    halted = 1'b1;
                end else if (op[5:3] != 3'd6 && op[2:0] != 3'd6) begin
                    regs[op[5:3]] = regs[op[2:0]];
                end
            end
            2'b10: begin
                if (op[2:0] != 3'd6) begin
                    t = alu_ref(op[5:3], regs[7], regs[op[2:0]], carry);
                    regs[7] = t[7:0];
                    carry = t[8];
                end
            end
            default: begin
                // OUT (n),A puts A on the high address byte
                if (op == 8'hD3) begin
                    exp_port.push_back(image[(pc + 1) % IMAGE_BYTES]);
                    exp_data.push_back(regs[7]);
                    io_expected++;
                    len = 2;
                end
            end
        endcase
        pc = pc + 16'(len);
    end
endfunction

initial begin
    error_count = 0;
    io_seen = 0;
    fetch_seen = 0;
    last_n_wr = 1'b1;
    final_done = 1'b0;
    wait (image_ready === 1'b1);
    predict_bus_trace();
end

// Strobes are idle and the bus is released while in reset
always @(negedge clk) begin
    if (!rst_n) begin
        if ({n_m1, n_mreq, n_iorq, n_rd, n_wr, n_halt} !== 6'h3f) begin
            $display("CHECK FAILED: {n_m1,n_mreq,n_iorq,n_rd,n_wr,n_halt} got %h expected %h",
                     {n_m1, n_mreq, n_iorq, n_rd, n_wr, n_halt}, 6'h3f);
            error_count++;
        end
        if (dout_en !== 1'b0) begin
            $display("CHECK FAILED: dout_en in reset got %h expected %h", dout_en, 1'b0);
            error_count++;
        end
    end
end

// Pin watcher; values seen here are the ones of the clock just ended
always @(posedge clk) begin
    if (rst_n) begin
        // T1 of a fetch is the only clock with n_m1 low and n_mreq high
        if (!n_m1 && n_mreq) begin
            if (exp_fetch.size() == 0) begin
                $display("fetch at %h after the end of the predicted program", addr);
                error_count++;
            end else begin
                want_addr = exp_fetch.pop_front();
                if (addr !== want_addr) begin
                    $display("CHECK FAILED: addr of fetch %0d got %h expected %h",
                             fetch_seen, addr, want_addr);
                    error_count++;
                end
            end
            fetch_seen++;
        end
        // First clock of an I/O write
        if (!n_wr && last_n_wr) begin
            io_seen++;
            // Only the I/O request goes low beside the write strobe
            if ({n_iorq, n_mreq, n_rd} !== 3'b011) begin
                $display("CHECK FAILED: {n_iorq,n_mreq,n_rd} got %h expected %h",
                         {n_iorq, n_mreq, n_rd}, 3'b011);
                error_count++;
            end
            if (exp_port.size() == 0) begin
                $display("I/O write to %h that the model does not predict", addr);
                error_count++;
            end else begin
                want_port = exp_port.pop_front();
                want_data = exp_data.pop_front();
                if (addr[7:0] !== want_port) begin
                    $display("CHECK FAILED: addr[7:0] got %h expected %h", addr[7:0], want_port);
                    error_count++;
                end
                if (addr[15:8] !== want_data) begin
                    $display("CHECK FAILED: addr[15:8] got %h expected %h",
                             addr[15:8], want_data);
                    error_count++;
                end
                if (dout !== want_data || dout_en !== 1'b1) begin
                    $display("CHECK FAILED: dout got %h expected %h (dout_en %h)",
                             dout, want_data, dout_en);
                    error_count++;
                end
            end
        end
        last_n_wr = n_wr;
        // Halted core keeps the bus quiet
        if (!n_halt && (!n_m1 || !n_mreq || !n_iorq || !n_rd || !n_wr)) begin
            $display("a bus strobe went active after HALT");
            error_count++;
        end
        if (run_done && !final_done) begin
            final_done = 1'b1;
            if (exp_fetch.size() != 0) begin
                $display("%0d predicted fetches never happened", exp_fetch.size());
                error_count++;
            end
            if (io_seen != io_expected) begin
                $display("CHECK FAILED: I/O write count got %h expected %h",
                         io_seen, io_expected);
                error_count++;
            end
        end
    end
end

endmodule

/* verilog/z80_top.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Reduced Z80 core top level; wires the control,
// register file and ALU to the CPU pins
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "z80_macros.svh"

module z80_top import z80_isa_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [`Z80_DATA_W-1:0] din,
    input  logic                   n_wait,
    output logic [`Z80_ADDR_W-1:0] addr,
    output logic [`Z80_DATA_W-1:0] dout,
    output logic                   dout_en,
    output logic                   n_m1,
    output logic                   n_mreq,
    output logic                   n_iorq,
    output logic                   n_rd,
    output logic                   n_wr,
    output logic                   n_halt
);

// Decoded instruction fields
instr_t   instr;
reg_sel_t dst;
reg_sel_t src;
alu_op_t  alu_op;

// Sequencer strobes
logic ir_load;
logic wr_imm;
logic wr_reg;
logic wr_alu;
logic port_load;

// Data path between registers and ALU
logic [`Z80_DATA_W-1:0] a_val;
logic [`Z80_DATA_W-1:0] src_val;
logic [`Z80_DATA_W-1:0] result;
logic [`Z80_DATA_W-1:0] port;

//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Control: bus timing and instruction decode
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
sequencer i_sequencer (
    .clk       (clk),
    .rst_n     (rst_n),
    .n_wait    (n_wait),
    .instr     (instr),
    .a_val     (a_val),
    .port      (port),
    .addr      (addr),
    .n_m1      (n_m1),
    .n_mreq    (n_mreq),
    .n_iorq    (n_iorq),
    .n_rd      (n_rd),
    .n_wr      (n_wr),
    .n_halt    (n_halt),
    .ir_load   (ir_load),
    .wr_imm    (wr_imm),
    .wr_reg    (wr_reg),
    .wr_alu    (wr_alu),
    .port_load (port_load),
    .dout_en   (dout_en)
);

decode i_decode ( .clk, .rst_n, .ir_load, .din, .instr, .dst, .src, .alu_op );

//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Data path: registers and ALU with flags
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
reg_file i_reg_file ( .clk, .rst_n, .din, .dst, .src, .result, .wr_imm, .wr_reg,
                      .wr_alu, .port_load, .a_val, .src_val, .dout, .port );

alu i_alu ( .clk, .rst_n, .a_val, .src_val, .alu_op, .wr_alu, .result );

endmodule

/* control/sequencer.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Machine-cycle and T-state sequencer; owns the PC,
// the address bus and all bus strobes
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "z80_macros.svh"

module sequencer import z80_isa_pkg::*; import z80_bus_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   n_wait,
    input  instr_t                 instr,
    input  logic [`Z80_DATA_W-1:0] a_val,
    input  logic [`Z80_DATA_W-1:0] port,
    output logic [`Z80_ADDR_W-1:0] addr,
    output logic                   n_m1,
    output logic                   n_mreq,
    output logic                   n_iorq,
    output logic                   n_rd,
    output logic                   n_wr,
    output logic                   n_halt,
    output logic                   ir_load,
    output logic                   wr_imm,
    output logic                   wr_reg,
    output logic                   wr_alu,
    output logic                   port_load,
    output logic                   dout_en
);

logic [`Z80_ADDR_W-1:0] pc;
mcycle_t mcycle;
mcycle_t mcycle_next;
tstate_t tstate;
logic    busy;
logic    hold_clk;
logic    strobe_phase;
logic    t3_end;
logic    mem_cycle;

// Master hold: freeze timing in TW while the bus asks for wait
assign hold_clk = !n_wait && (tstate == T2 || tstate == TW);

// Next machine cycle; instr already shows the new opcode during fetch T3
always_comb begin
    mcycle_next = MC_FETCH;
    case (mcycle)
        MC_FETCH: begin
            if (instr == I_LD_IMM || instr == I_OUT) begin
                mcycle_next = MC_MEM_RD;
            end else if (instr == I_HALT) begin
                mcycle_next = MC_HALTED;
            end
        end
        MC_MEM_RD: if (instr == I_OUT) mcycle_next = MC_IO_WR;
        MC_HALTED: mcycle_next = MC_HALTED;
        default:   mcycle_next = MC_FETCH;
    endcase
end

// One idle clock out of reset, then T1 of the first fetch
always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        busy   <= 1'b0;
        mcycle <= MC_FETCH;
        tstate <= T1;
        pc     <= `Z80_RESET_PC;
    end else if (!busy) begin
        busy <= 1'b1;
    end else if (mcycle != MC_HALTED) begin
        case (tstate)
            T1:      tstate <= T2;
            T2, TW:  tstate <= hold_clk ? TW : T3;
            default: begin
                // End of T3: the cycle is done
                tstate <= T1;
                mcycle <= mcycle_next;
                if (mcycle != MC_IO_WR) pc <= pc + 1'b1;
            end
        endcase
    end
end

//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Pins and internal write strobes
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
assign strobe_phase = busy && tstate != T1;
assign mem_cycle    = mcycle == MC_FETCH || mcycle == MC_MEM_RD;
assign t3_end       = busy && tstate == T3;

assign n_m1    = !(busy && mcycle == MC_FETCH);
assign n_mreq  = !(strobe_phase && mem_cycle);
assign n_rd    = !(strobe_phase && mem_cycle);
assign n_iorq  = !(strobe_phase && mcycle == MC_IO_WR);
assign n_wr    = !(strobe_phase && mcycle == MC_IO_WR);
assign n_halt  = mcycle != MC_HALTED;
assign dout_en = busy && mcycle == MC_IO_WR;

// I/O write puts A on the high byte, the port byte below it
assign addr = (mcycle == MC_IO_WR) ? {a_val, port} : pc;

// Opcode latch and single-cycle writes land on the fetch T3 edge
assign ir_load   = t3_end && mcycle == MC_FETCH;
assign wr_reg    = ir_load && instr == I_LD_REG;
assign wr_alu    = ir_load && instr == I_ALU;
assign wr_imm    = t3_end && mcycle == MC_MEM_RD && instr == I_LD_IMM;
assign port_load = t3_end && mcycle == MC_MEM_RD && instr == I_OUT;

// Read and write never overlap on the pins
a_rd_wr_excl: assert property (@(posedge clk) disable iff (!rst_n) n_rd || n_wr);

// Memory and I/O requests are never both active
a_mreq_iorq_excl: assert property (@(posedge clk) disable iff (!rst_n) n_mreq || n_iorq);

endmodule

/* control/decode.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Instruction register and decoder; splits the
// opcode into class, register codes and ALU op
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "z80_macros.svh"

module decode import z80_isa_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   ir_load,
    input  logic [`Z80_DATA_W-1:0] din,
    output instr_t                 instr,
    output reg_sel_t               dst,
    output reg_sel_t               src,
    output alu_op_t                alu_op
);

logic [`Z80_DATA_W-1:0] ir;
logic [`Z80_DATA_W-1:0] opcode;
logic [1:0] op_x;
logic [2:0] op_y;
logic [2:0] op_z;

always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        ir <= '0;
    end else if (ir_load) begin
        ir <= din;
    end
end

// Bypass: during fetch T3 the byte on din is decoded directly
assign opcode = ir_load ? din : ir;

// Z80 field split x[7:6] y[5:3] z[2:0]
assign op_x = opcode[7:6];
assign op_y = opcode[5:3];
assign op_z = opcode[2:0];

assign dst    = reg_sel_t'(op_y);
assign src    = reg_sel_t'(op_z);
assign alu_op = alu_op_t'(op_y);

// (HL) operands and everything outside the subset fall to NOP
always_comb begin
    instr = I_NOP;
    case (op_x)
        2'd0: if (op_z == 3'd6 && dst != REG_HL) instr = I_LD_IMM;
        2'd1: begin
            if (opcode == OP_HALT) begin
                instr = I_HALT;
            end else if (dst != REG_HL && src != REG_HL) begin
                instr = I_LD_REG;
            end
        end
        2'd2: if (src != REG_HL) instr = I_ALU;
        default: if (opcode == OP_OUT_N) instr = I_OUT;
    endcase
end

a_instr_known: assert property (@(posedge clk) disable iff (!rst_n) !$isunknown(instr));

endmodule

/* verilog/reg_file.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Registers B..L and A, the OUT port byte, and the
// write-source mux fed by the sequencer strobes
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "z80_macros.svh"

module reg_file import z80_isa_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [`Z80_DATA_W-1:0] din,
    input  reg_sel_t               dst,
    input  reg_sel_t               src,
    input  logic [`Z80_DATA_W-1:0] result,
    input  logic                   wr_imm,
    input  logic                   wr_reg,
    input  logic                   wr_alu,
    input  logic                   port_load,
    output logic [`Z80_DATA_W-1:0] a_val,
    output logic [`Z80_DATA_W-1:0] src_val,
    output logic [`Z80_DATA_W-1:0] dout,
    output logic [`Z80_DATA_W-1:0] port
);

localparam int NUM_REGS = 7;
localparam int A_IDX    = 6;

logic [`Z80_DATA_W-1:0] regs [NUM_REGS];
logic [`Z80_DATA_W-1:0] wr_data;
logic [2:0]             wr_idx;
logic                   wr_en;

// A takes the slot of (HL), which never reaches a write strobe
function automatic logic [2:0] reg_index(reg_sel_t sel);
    return (sel == REG_A) ? 3'(A_IDX) : 3'(sel);
endfunction

assign a_val   = regs[A_IDX];
assign src_val = regs[reg_index(src)];
assign dout    = a_val;

// Write source: ALU result to A, else register copy or immediate
always_comb begin
    wr_data = din;
    wr_idx  = reg_index(dst);
    if (wr_alu) begin
        wr_data = result;
        wr_idx  = 3'(A_IDX);
    end else if (wr_reg) begin
        wr_data = src_val;
    end
end

assign wr_en = wr_imm | wr_reg | wr_alu;

always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        for (int i = 0; i < NUM_REGS; i++) begin
            regs[i] <= '0;
        end
    end else if (wr_en) begin
        regs[wr_idx] <= wr_data;
    end
end

// Port byte of OUT (n),A
always_ff @(posedge clk) begin
    if (port_load) port <= din;
end

a_wr_onehot: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0({wr_imm, wr_reg, wr_alu, port_load}));

endmodule

/* verilog/alu.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 8-bit accumulator ALU with Z80 flag rules and
// the F register; carry feeds ADC and SBC
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "z80_macros.svh"

module alu import z80_isa_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [`Z80_DATA_W-1:0] a_val,
    input  logic [`Z80_DATA_W-1:0] src_val,
    input  alu_op_t                alu_op,
    input  logic                   wr_alu,
    output logic [`Z80_DATA_W-1:0] result
);

logic [`Z80_DATA_W-1:0] flags;
logic [`Z80_DATA_W-1:0] flags_next;
logic [`Z80_DATA_W-1:0] b_eff;
logic [`Z80_DATA_W-1:0] res;
logic [`Z80_DATA_W:0]   sum;
logic [4:0]             half_sum;
logic                   is_sub;
logic                   is_logic;
logic                   carry_in;
logic                   cin_eff;

assign is_sub   = alu_op inside {ALU_SUB, ALU_SBC, ALU_CP};
assign is_logic = alu_op inside {ALU_AND, ALU_XOR, ALU_OR};
assign carry_in = (alu_op == ALU_ADC || alu_op == ALU_SBC) ? flags[FLAG_C] : 1'b0;

// Subtract as a + ~b + ~borrow
assign b_eff    = is_sub ? ~src_val : src_val;
assign cin_eff  = is_sub ? ~carry_in : carry_in;
assign sum      = {1'b0, a_val} + {1'b0, b_eff} + {{`Z80_DATA_W{1'b0}}, cin_eff};
assign half_sum = {1'b0, a_val[3:0]} + {1'b0, b_eff[3:0]} + {4'b0000, cin_eff};

always_comb begin
    flags_next = '0;
    case (alu_op)
        ALU_AND: res = a_val & src_val;
        ALU_XOR: res = a_val ^ src_val;
        ALU_OR:  res = a_val | src_val;
        default: res = sum[`Z80_DATA_W-1:0];
    endcase
    flags_next[FLAG_S] = res[`Z80_DATA_W-1];
    flags_next[FLAG_Z] = (res == '0);
    flags_next[FLAG_N] = is_sub;
    if (is_logic) begin
        // H set only by AND, P/V is even parity
        flags_next[FLAG_H]  = (alu_op == ALU_AND);
        flags_next[FLAG_PV] = ~^res;
        flags_next[FLAG_C]  = 1'b0;
    end else begin
        // Carry outs turn into borrows when subtracting
        flags_next[FLAG_H]  = half_sum[4] ^ is_sub;
        flags_next[FLAG_PV] = (a_val[7] == b_eff[7]) && (res[7] != a_val[7]);
        flags_next[FLAG_C]  = sum[`Z80_DATA_W] ^ is_sub;
    end
end

// CP hands A back unchanged, only the flags move
assign result = (alu_op == ALU_CP) ? a_val : res;

always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        flags <= '0;
    end else if (wr_alu) begin
        flags <= flags_next;
    end
end

endmodule

/* common/z80_bus_pkg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bus-timing types: machine-cycle kinds and
// T-states used by the sequencer and the bench
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package z80_bus_pkg;

    // Kind of machine cycle on the pins
    // HALTED runs no bus cycle at all
    typedef enum logic [1:0] {
        MC_FETCH,
        MC_MEM_RD,
        MC_IO_WR,
        MC_HALTED
    } mcycle_t;

    // T-state inside a machine cycle
    // TW repeats for as long as n_wait stays low
    typedef enum logic [1:0] {
        T1,
        T2,
        TW,
        T3
    } tstate_t;

endpackage

/* common/z80_isa_pkg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Instruction-set types for the reduced Z80 core:
// ALU ops, register codes, classes, flag bits
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package z80_isa_pkg;

    // Accumulator ops, same order as opcode bits 5:3
    typedef enum logic [2:0] {
        ALU_ADD, ALU_ADC, ALU_SUB, ALU_SBC,
        ALU_AND, ALU_XOR, ALU_OR,  ALU_CP
    } alu_op_t;

    // Register codes as found in the y and z fields
    typedef enum logic [2:0] {
        REG_B, REG_C, REG_D, REG_E,
        REG_H, REG_L, REG_HL, REG_A
    } reg_sel_t;

    // Instruction classes the core can execute
    typedef enum logic [2:0] {
        I_NOP, I_LD_IMM, I_LD_REG, I_ALU, I_OUT, I_HALT
    } instr_t;

    // Bit positions inside the F register
    localparam int FLAG_C  = 0;
    localparam int FLAG_N  = 1;
    localparam int FLAG_PV = 2;
    localparam int FLAG_H  = 4;
    localparam int FLAG_Z  = 6;
    localparam int FLAG_S  = 7;

    // Opcodes that are matched in full
    localparam logic [7:0] OP_HALT  = 8'h76;
    localparam logic [7:0] OP_OUT_N = 8'hD3;

endpackage

/* common/z80_macros.svh */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bus widths and run limits shared by the CPU core
// and the bench; include wherever a width is needed
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef Z80_MACROS_SVH
`define Z80_MACROS_SVH

// Data bus, one byte
`define Z80_DATA_W 8

// Address bus, 64K space
`define Z80_ADDR_W 16

// Address of the first opcode fetch after reset
`define Z80_RESET_PC 16'h0000

// Upper bound of wait clocks the bench adds per machine cycle
`define Z80_MAX_WAIT 3

`endif
